//--- verilog/cfu_pkg.sv
// Shared widths, micro-op encoding and statistics register map for the
// control-flow execute unit. RTL and testbench refer to these by scoped
// names.

package cfu_pkg;

  //--------------------------------------------------
  // Datapath widths
  //--------------------------------------------------

  // Reorder buffer sequence number
  localparam int SEQ_BITS = 5;

  // Data and address width
  localparam int XLEN = 32;

  // Architectural register address
  localparam int REG_BITS = 5;

  //--------------------------------------------------
  // Micro-op encoding
  //--------------------------------------------------

  // Only the control-flow ops reach this unit
  typedef enum logic [1:0] {
    UOP_JAL  = 2'd0,
    UOP_JALR = 2'd1,
    UOP_BNE  = 2'd2
  } cfu_uop_e;

  //--------------------------------------------------
  // Statistics block word offsets
  //--------------------------------------------------

  localparam int STAT_ADR_BITS = 2;

  // Counters, read only
  localparam logic [STAT_ADR_BITS-1:0] STAT_RETIRED = 2'd0;
  localparam logic [STAT_ADR_BITS-1:0] STAT_LINK    = 2'd1;
  localparam logic [STAT_ADR_BITS-1:0] STAT_SQUASH  = 2'd2;

  // Bit 0 written high clears all counters, reads as zero
  localparam logic [STAT_ADR_BITS-1:0] STAT_CTRL    = 2'd3;

endpackage

//--- verilog/cfu_issue_buffer.sv
// Two-entry FIFO between dispatch and the control-flow unit.
// Dispatch sees a registered ready, so no combinational path runs
// from the unit back to dispatch.

`timescale 1ns/1ps

module cfu_issue_buffer (
  input  logic                          clk,
  input  logic                          arst_n,
  // Dispatch side
  input  logic                          d_val,
  output logic                          d_rdy,
  input  logic [cfu_pkg::XLEN-1:0]      d_pc,
  input  logic [cfu_pkg::SEQ_BITS-1:0]  d_seq_num,
  input  logic [cfu_pkg::XLEN-1:0]      d_op1,
  input  logic [cfu_pkg::XLEN-1:0]      d_op2,
  input  logic [cfu_pkg::XLEN-1:0]      d_imm,
  input  logic [cfu_pkg::REG_BITS-1:0]  d_waddr,
  input  cfu_pkg::cfu_uop_e             d_uop,
  // Execute side
  output logic                          x_val,
  input  logic                          x_rdy,
  output logic [cfu_pkg::XLEN-1:0]      x_pc,
  output logic [cfu_pkg::SEQ_BITS-1:0]  x_seq_num,
  output logic [cfu_pkg::XLEN-1:0]      x_op1,
  output logic [cfu_pkg::XLEN-1:0]      x_op2,
  output logic [cfu_pkg::XLEN-1:0]      x_imm,
  output logic [cfu_pkg::REG_BITS-1:0]  x_waddr,
  output cfu_pkg::cfu_uop_e             x_uop
);

  // Entry storage
  logic [cfu_pkg::XLEN-1:0]     pc_q    [2];
  logic [cfu_pkg::SEQ_BITS-1:0] seq_q   [2];
  logic [cfu_pkg::XLEN-1:0]     op1_q   [2];
  logic [cfu_pkg::XLEN-1:0]     op2_q   [2];
  logic [cfu_pkg::XLEN-1:0]     imm_q   [2];
  logic [cfu_pkg::REG_BITS-1:0] waddr_q [2];
  cfu_pkg::cfu_uop_e            uop_q   [2];

  logic       head_q;
  logic       tail_q;
  logic [1:0] count_q;
  logic [1:0] count_next;
  logic       d_rdy_q;
  logic       d_fire;
  logic       x_fire;

  assign d_fire = d_val & d_rdy_q;
  assign x_fire = x_val & x_rdy;

  // Occupancy after this edge
  always_comb begin
    case ({d_fire, x_fire})
      2'b10:   count_next = count_q + 2'd1;
      2'b01:   count_next = count_q - 2'd1;
      default: count_next = count_q;
    endcase
  end

  //--------------------------------------------------
  // Pointers, count and registered ready
  //--------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head_q  <= 1'b0;
      tail_q  <= 1'b0;
      count_q <= 2'd0;
      d_rdy_q <= 1'b1;
    end else begin
      if (d_fire) begin
        tail_q <= ~tail_q;
      end
      if (x_fire) begin
        head_q <= ~head_q;
      end
      count_q <= count_next;
      // Ready drops only once both entries hold ops
      d_rdy_q <= (count_next != 2'd2);
    end
  end

  // Payload write at tail
  always_ff @(posedge clk) begin
    if (d_fire) begin
      pc_q[tail_q]    <= d_pc;
      seq_q[tail_q]   <= d_seq_num;
      op1_q[tail_q]   <= d_op1;
      op2_q[tail_q]   <= d_op2;
      imm_q[tail_q]   <= d_imm;
      waddr_q[tail_q] <= d_waddr;
      uop_q[tail_q]   <= d_uop;
    end
  end

  assign d_rdy = d_rdy_q;

  // Head entry presented to the unit
  assign x_val     = (count_q != 2'd0);
  assign x_pc      = pc_q[head_q];
  assign x_seq_num = seq_q[head_q];
  assign x_op1     = op1_q[head_q];
  assign x_op2     = op2_q[head_q];
  assign x_imm     = imm_q[head_q];
  assign x_waddr   = waddr_q[head_q];
  assign x_uop     = uop_q[head_q];

endmodule

//--- verilog/control_flow_unit.sv
// Control-flow execute unit for JAL, JALR and BNE.
// Resolves target and link value, registers the writeback message and
// pulses squash once per redirecting op.

`timescale 1ns/1ps

module control_flow_unit (
  input  logic                          clk,
  input  logic                          arst_n,
  // Issue side
  input  logic                          x_val,
  output logic                          x_rdy,
  input  logic [cfu_pkg::XLEN-1:0]      x_pc,
  input  logic [cfu_pkg::SEQ_BITS-1:0]  x_seq_num,
  input  logic [cfu_pkg::XLEN-1:0]      x_op1,
  input  logic [cfu_pkg::XLEN-1:0]      x_op2,
  input  logic [cfu_pkg::XLEN-1:0]      x_imm,
  input  logic [cfu_pkg::REG_BITS-1:0]  x_waddr,
  input  cfu_pkg::cfu_uop_e             x_uop,
  // Writeback stream
  output logic                          w_val,
  input  logic                          w_rdy,
  output logic [cfu_pkg::XLEN-1:0]      w_pc,
  output logic [cfu_pkg::SEQ_BITS-1:0]  w_seq_num,
  output logic [cfu_pkg::REG_BITS-1:0]  w_waddr,
  output logic [cfu_pkg::XLEN-1:0]      w_wdata,
  output logic                          w_wen,
  // Squash notification
  output logic                          squash_val,
  output logic [cfu_pkg::SEQ_BITS-1:0]  squash_seq_num,
  output logic [cfu_pkg::XLEN-1:0]      squash_target
);

  logic                         load;
  logic [cfu_pkg::XLEN-1:0]     link;
  logic [cfu_pkg::XLEN-1:0]     jalr_sum;
  logic [cfu_pkg::XLEN-1:0]     target;
  logic                         taken;
  logic                         wen;

  logic                         w_val_q;
  logic                         first_q;
  logic                         taken_q;
  logic [cfu_pkg::XLEN-1:0]     target_q;

  //--------------------------------------------------
  // Resolution
  //--------------------------------------------------

  // Return address for jumps
  assign link     = x_pc + cfu_pkg::XLEN'(4);
  assign jalr_sum = x_op1 + x_imm;

  always_comb begin
    target = x_pc + x_imm;
    taken  = 1'b0;
    wen    = 1'b0;
    case (x_uop)
      cfu_pkg::UOP_JAL: begin
        taken = 1'b1;
        wen   = 1'b1;
      end
      cfu_pkg::UOP_JALR: begin
        // Target LSB forced to zero
        target = {jalr_sum[cfu_pkg::XLEN-1:1], 1'b0};
        taken  = 1'b1;
        wen    = 1'b1;
      end
      cfu_pkg::UOP_BNE: begin
        taken = (x_op1 != x_op2);
      end
      default: begin
        taken = 1'b0;
      end
    endcase
  end

  //--------------------------------------------------
  // Writeback register
  //--------------------------------------------------

  // Accept when empty or draining this edge
  assign x_rdy = ~w_val_q | w_rdy;
  assign load  = x_val & x_rdy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      w_val_q <= 1'b0;
      first_q <= 1'b0;
    end else begin
      if (load) begin
        w_val_q <= 1'b1;
      end else if (w_rdy) begin
        w_val_q <= 1'b0;
      end
      // Set only in the cycle right after a load
      first_q <= load;
    end
  end

  // Message payload, held while W stalls
  always_ff @(posedge clk) begin
    if (load) begin
      w_pc      <= x_pc;
      w_seq_num <= x_seq_num;
      w_waddr   <= wen ? x_waddr : '0;
      w_wdata   <= wen ? link : '0;
      w_wen     <= wen;
      taken_q   <= taken;
      target_q  <= target;
    end
  end

  assign w_val = w_val_q;

  // One pulse per taken op, even under back-pressure
  assign squash_val     = w_val_q & first_q & taken_q;
  assign squash_seq_num = w_seq_num;
  assign squash_target  = target_q;

endmodule

//--- verilog/cfu_stat_regs.sv
// Wishbone classic slave with retire, link-write and squash counters.
// Watches the writeback stream and squash pulse of the unit.

`timescale 1ns/1ps

module cfu_stat_regs (
  input  logic                              clk,
  input  logic                              arst_n,
  // Wishbone slave
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [cfu_pkg::STAT_ADR_BITS-1:0] wb_adr,
  input  logic [cfu_pkg::XLEN-1:0]          wb_wdata,
  output logic [cfu_pkg::XLEN-1:0]          wb_rdata,
  output logic                              wb_ack,
  // Observed events
  input  logic                              w_val,
  input  logic                              w_rdy,
  input  logic                              w_wen,
  input  logic                              squash_val
);

  logic [cfu_pkg::XLEN-1:0] retired_q;
  logic [cfu_pkg::XLEN-1:0] link_q;
  logic [cfu_pkg::XLEN-1:0] squash_q;
  logic [cfu_pkg::XLEN-1:0] rd_mux;
  logic                     req;
  logic                     clear;
  logic                     w_fire;

  //--------------------------------------------------
  // Bus handshake
  //--------------------------------------------------

  // New request, ack not yet given
  assign req   = wb_cyc & wb_stb & ~wb_ack;
  assign clear = req & wb_we & (wb_adr == cfu_pkg::STAT_CTRL) & wb_wdata[0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  // Read decode, control register reads zero
  always_comb begin
    case (wb_adr)
      cfu_pkg::STAT_RETIRED: rd_mux = retired_q;
      cfu_pkg::STAT_LINK:    rd_mux = link_q;
      cfu_pkg::STAT_SQUASH:  rd_mux = squash_q;
      default:               rd_mux = '0;
    endcase
  end

  // Data lands together with ack
  always_ff @(posedge clk) begin
    if (req) begin
      wb_rdata <= rd_mux;
    end
  end

  //--------------------------------------------------
  // Event counters
  //--------------------------------------------------

  assign w_fire = w_val & w_rdy;

  // Clear takes priority over any increment
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      retired_q <= '0;
      link_q    <= '0;
      squash_q  <= '0;
    end else if (clear) begin
      retired_q <= '0;
      link_q    <= '0;
      squash_q  <= '0;
    end else begin
      if (w_fire) begin
        retired_q <= retired_q + 1'b1;
      end
      if (w_fire && w_wen) begin
        link_q <= link_q + 1'b1;
      end
      if (squash_val) begin
        squash_q <= squash_q + 1'b1;
      end
    end
  end

endmodule

//--- verilog/cfu_top.sv
// Control-flow execute subsystem.
// Issue buffer feeds the unit; statistics block watches its outputs.

`timescale 1ns/1ps

module cfu_top (
  input  logic                              clk,
  input  logic                              arst_n,
  // Dispatch stream
  input  logic                              d_val,
  output logic                              d_rdy,
  input  logic [cfu_pkg::XLEN-1:0]          d_pc,
  input  logic [cfu_pkg::SEQ_BITS-1:0]      d_seq_num,
  input  logic [cfu_pkg::XLEN-1:0]          d_op1,
  input  logic [cfu_pkg::XLEN-1:0]          d_op2,
  input  logic [cfu_pkg::XLEN-1:0]          d_imm,
  input  logic [cfu_pkg::REG_BITS-1:0]      d_waddr,
  input  cfu_pkg::cfu_uop_e                 d_uop,
  // Writeback stream
  output logic                              w_val,
  input  logic                              w_rdy,
  output logic [cfu_pkg::XLEN-1:0]          w_pc,
  output logic [cfu_pkg::SEQ_BITS-1:0]      w_seq_num,
  output logic [cfu_pkg::REG_BITS-1:0]      w_waddr,
  output logic [cfu_pkg::XLEN-1:0]          w_wdata,
  output logic                              w_wen,
  // Squash
  output logic                              squash_val,
  output logic [cfu_pkg::SEQ_BITS-1:0]      squash_seq_num,
  output logic [cfu_pkg::XLEN-1:0]          squash_target,
  // Statistics bus
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [cfu_pkg::STAT_ADR_BITS-1:0] wb_adr,
  input  logic [cfu_pkg::XLEN-1:0]          wb_wdata,
  output logic [cfu_pkg::XLEN-1:0]          wb_rdata,
  output logic                              wb_ack
);

  // Buffer to unit
  logic                         x_val;
  logic                         x_rdy;
  logic [cfu_pkg::XLEN-1:0]     x_pc;
  logic [cfu_pkg::SEQ_BITS-1:0] x_seq_num;
  logic [cfu_pkg::XLEN-1:0]     x_op1;
  logic [cfu_pkg::XLEN-1:0]     x_op2;
  logic [cfu_pkg::XLEN-1:0]     x_imm;
  logic [cfu_pkg::REG_BITS-1:0] x_waddr;
  cfu_pkg::cfu_uop_e            x_uop;

  cfu_issue_buffer u_buf (
    .clk       (clk),
    .arst_n    (arst_n),
    .d_val     (d_val),
    .d_rdy     (d_rdy),
    .d_pc      (d_pc),
    .d_seq_num (d_seq_num),
    .d_op1     (d_op1),
    .d_op2     (d_op2),
    .d_imm     (d_imm),
    .d_waddr   (d_waddr),
    .d_uop     (d_uop),
    .x_val     (x_val),
    .x_rdy     (x_rdy),
    .x_pc      (x_pc),
    .x_seq_num (x_seq_num),
    .x_op1     (x_op1),
    .x_op2     (x_op2),
    .x_imm     (x_imm),
    .x_waddr   (x_waddr),
    .x_uop     (x_uop)
  );

  control_flow_unit u_cfu (
    .clk            (clk),
    .arst_n         (arst_n),
    .x_val          (x_val),
    .x_rdy          (x_rdy),
    .x_pc           (x_pc),
    .x_seq_num      (x_seq_num),
    .x_op1          (x_op1),
    .x_op2          (x_op2),
    .x_imm          (x_imm),
    .x_waddr        (x_waddr),
    .x_uop          (x_uop),
    .w_val          (w_val),
    .w_rdy          (w_rdy),
    .w_pc           (w_pc),
    .w_seq_num      (w_seq_num),
    .w_waddr        (w_waddr),
    .w_wdata        (w_wdata),
    .w_wen          (w_wen),
    .squash_val     (squash_val),
    .squash_seq_num (squash_seq_num),
    .squash_target  (squash_target)
  );

  // Observes W and squash only
  cfu_stat_regs u_stat (
    .clk        (clk),
    .arst_n     (arst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_wdata   (wb_wdata),
    .wb_rdata   (wb_rdata),
    .wb_ack     (wb_ack),
    .w_val      (w_val),
    .w_rdy      (w_rdy),
    .w_wen      (w_wen),
    .squash_val (squash_val)
  );

endmodule

//--- testbench/cfu_sva.sv
// Concurrent checks on the D and W handshakes, the squash pulse and the
// Wishbone ack. Bound into the subsystem top level.

`timescale 1ns/1ps

module cfu_sva (
  input logic                              clk,
  input logic                              arst_n,
  input logic                              d_val,
  input logic                              d_rdy,
  input logic [cfu_pkg::XLEN-1:0]          d_pc,
  input logic [cfu_pkg::SEQ_BITS-1:0]      d_seq_num,
  input logic [cfu_pkg::XLEN-1:0]          d_op1,
  input logic [cfu_pkg::XLEN-1:0]          d_op2,
  input logic [cfu_pkg::XLEN-1:0]          d_imm,
  input logic [cfu_pkg::REG_BITS-1:0]      d_waddr,
  input cfu_pkg::cfu_uop_e                 d_uop,
  input logic                              w_val,
  input logic                              w_rdy,
  input logic [cfu_pkg::XLEN-1:0]          w_pc,
  input logic [cfu_pkg::SEQ_BITS-1:0]      w_seq_num,
  input logic [cfu_pkg::REG_BITS-1:0]      w_waddr,
  input logic [cfu_pkg::XLEN-1:0]          w_wdata,
  input logic                              w_wen,
  input logic                              squash_val,
  input logic                              wb_ack
);

  // Running count of failed assertions
  int fail_count = 0;

  // Dispatch payload held until accepted
  assert property (@(posedge clk) disable iff (!arst_n)
    d_val && !d_rdy |=> d_val &&
      $stable({d_pc, d_seq_num, d_op1, d_op2, d_imm, d_waddr, d_uop}))
    else begin
      fail_count = fail_count + 1;
      $error("D stream payload changed while stalled");
    end

  // Writeback message held under back-pressure
  assert property (@(posedge clk) disable iff (!arst_n)
    w_val && !w_rdy |=> w_val && $stable({w_pc, w_seq_num, w_waddr, w_wdata, w_wen}))
    else begin
      fail_count = fail_count + 1;
      $error("W stream payload changed while stalled");
    end

  // Squash fires once even if W stalls
  assert property (@(posedge clk) disable iff (!arst_n)
    squash_val && !w_rdy |=> !squash_val)
    else begin
      fail_count = fail_count + 1;
      $error("squash_val repeated for a held W message");
    end

  // Single-cycle ack
  assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |=> !wb_ack)
    else begin
      fail_count = fail_count + 1;
      $error("wb_ack high for more than one cycle");
    end

endmodule

bind cfu_top cfu_sva u_sva (.*);

//--- testbench/cfu_tb.sv
// Directed testbench for the control-flow execute subsystem.
// Sends JAL, JALR and BNE ops, checks writeback, squash and statistics
// against a queue-based reference model.

`timescale 1ns/1ps

module cfu_tb;

  // Roughly 65 ops of a few cycles each plus bus reads fit well inside this
  localparam int CYCLE_LIMIT = 4000;

  logic                              clk;
  logic                              arst_n;
  logic                              d_val;
  logic                              d_rdy;
  logic [cfu_pkg::XLEN-1:0]          d_pc;
  logic [cfu_pkg::SEQ_BITS-1:0]      d_seq_num;
  logic [cfu_pkg::XLEN-1:0]          d_op1;
  logic [cfu_pkg::XLEN-1:0]          d_op2;
  logic [cfu_pkg::XLEN-1:0]          d_imm;
  logic [cfu_pkg::REG_BITS-1:0]      d_waddr;
  cfu_pkg::cfu_uop_e                 d_uop;
  logic                              w_val;
  logic                              w_rdy;
  logic [cfu_pkg::XLEN-1:0]          w_pc;
  logic [cfu_pkg::SEQ_BITS-1:0]      w_seq_num;
  logic [cfu_pkg::REG_BITS-1:0]      w_waddr;
  logic [cfu_pkg::XLEN-1:0]          w_wdata;
  logic                              w_wen;
  logic                              squash_val;
  logic [cfu_pkg::SEQ_BITS-1:0]      squash_seq_num;
  logic [cfu_pkg::XLEN-1:0]          squash_target;
  logic                              wb_cyc;
  logic                              wb_stb;
  logic                              wb_we;
  logic [cfu_pkg::STAT_ADR_BITS-1:0] wb_adr;
  logic [cfu_pkg::XLEN-1:0]          wb_wdata;
  logic [cfu_pkg::XLEN-1:0]          wb_rdata;
  logic                              wb_ack;

  // Reference model queues hold one entry per op in acceptance order
  cfu_pkg::cfu_uop_e            q_uop[$];
  logic [cfu_pkg::SEQ_BITS-1:0] q_seq[$];
  logic [cfu_pkg::XLEN-1:0]     q_pc[$];
  logic [cfu_pkg::REG_BITS-1:0] q_waddr[$];
  logic [cfu_pkg::XLEN-1:0]     q_wdata[$];
  logic                         q_wen[$];
  // Only redirecting ops
  logic [cfu_pkg::SEQ_BITS-1:0] q_sq_seq[$];
  logic [cfu_pkg::XLEN-1:0]     q_sq_tgt[$];

  integer                       seed = 32'h5e01;
  int                           cycles = 0;
  int                           n_retired;
  int                           n_link;
  int                           n_squash;
  logic [cfu_pkg::SEQ_BITS-1:0] next_seq;
  logic                         bp_done;

  cfu_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //--------------------------------------------------
  // Failure reporting and compare tasks
  //--------------------------------------------------

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  task automatic check_w_msg(input cfu_pkg::cfu_uop_e uop,
                             input logic [cfu_pkg::SEQ_BITS-1:0] seq,
                             input logic [cfu_pkg::XLEN-1:0] pc,
                             input logic [cfu_pkg::REG_BITS-1:0] waddr,
                             input logic [cfu_pkg::XLEN-1:0] wdata,
                             input logic wen);
    if (w_seq_num !== seq || w_pc !== pc || w_waddr !== waddr || w_wdata !== wdata ||
        w_wen !== wen) begin
      fail_run($sformatf(
        "Mismatch at %0t: %s W got seq %0d pc %h wa %0d wd %h wen %b, exp %0d %h %0d %h %b",
        $time, uop.name(), w_seq_num, w_pc, w_waddr, w_wdata, w_wen,
        seq, pc, waddr, wdata, wen));
    end
  endtask

  task automatic check_squash(input logic [cfu_pkg::SEQ_BITS-1:0] seq,
                              input logic [cfu_pkg::XLEN-1:0] target);
    if (squash_seq_num !== seq || squash_target !== target) begin
      fail_run($sformatf("Mismatch at %0t: squash got seq %0d target %h, exp %0d %h",
                         $time, squash_seq_num, squash_target, seq, target));
    end
  endtask

  task automatic wb_read(input logic [cfu_pkg::STAT_ADR_BITS-1:0] adr,
                         output logic [cfu_pkg::XLEN-1:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    data   = wb_rdata;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic wb_write(input logic [cfu_pkg::STAT_ADR_BITS-1:0] adr,
                          input logic [cfu_pkg::XLEN-1:0] data);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_wdata = data;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic check_stat(input logic [cfu_pkg::STAT_ADR_BITS-1:0] adr,
                            input logic [cfu_pkg::XLEN-1:0] expected);
    logic [cfu_pkg::XLEN-1:0] got;
    wb_read(adr, got);
    if (got !== expected) begin
      fail_run($sformatf("Mismatch at %0t: stat offset %0d read %0d, exp %0d",
                         $time, adr, got, expected));
    end
  endtask

  //--------------------------------------------------
  // Stimulus driven right after a falling edge
  //--------------------------------------------------

  task automatic send_op(input cfu_pkg::cfu_uop_e uop,
                         input logic [cfu_pkg::XLEN-1:0] pc,
                         input logic [cfu_pkg::XLEN-1:0] op1,
                         input logic [cfu_pkg::XLEN-1:0] op2,
                         input logic [cfu_pkg::XLEN-1:0] imm,
                         input logic [cfu_pkg::REG_BITS-1:0] waddr);
    logic                     jump;
    logic                     taken;
    logic [cfu_pkg::XLEN-1:0] target;
    jump   = (uop == cfu_pkg::UOP_JAL) || (uop == cfu_pkg::UOP_JALR);
    // Fetch predicts fall-through so any redirect squashes
    taken  = jump || (op1 != op2);
    target = pc + imm;
    if (uop == cfu_pkg::UOP_JALR) begin
      target = (op1 + imm) & ~cfu_pkg::XLEN'(1);
    end
    q_uop.push_back(uop);
    q_seq.push_back(next_seq);
    q_pc.push_back(pc);
    q_waddr.push_back(jump ? waddr : '0);
    q_wdata.push_back(jump ? pc + cfu_pkg::XLEN'(4) : '0);
    q_wen.push_back(jump);
    if (taken) begin
      q_sq_seq.push_back(next_seq);
      q_sq_tgt.push_back(target);
      n_squash++;
    end
    n_retired++;
    if (jump) begin
      n_link++;
    end
    d_val     = 1'b1;
    d_uop     = uop;
    d_pc      = pc;
    d_seq_num = next_seq;
    d_op1     = op1;
    d_op2     = op2;
    d_imm     = imm;
    d_waddr   = waddr;
    // Ready is registered and a high value here means transfer at next edge
    while (!d_rdy) @(negedge clk);
    @(negedge clk);
    d_val    = 1'b0;
    next_seq = next_seq + 1'b1;
  endtask

  task automatic drain();
    while (q_seq.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
    if (q_sq_seq.size() != 0) begin
      fail_run("A redirecting op completed without its squash notification");
    end
  endtask

  //--------------------------------------------------
  // Output monitor and timeout
  //--------------------------------------------------

  always @(posedge clk) begin
    if (arst_n) begin
      if (dut.u_sva.fail_count != 0) begin
        fail_run("An assertion in the bound checker failed");
      end
      if (squash_val) begin
        if (q_sq_seq.size() == 0) begin
          fail_run("Squash raised with no redirecting op outstanding");
        end else begin
          check_squash(q_sq_seq.pop_front(), q_sq_tgt.pop_front());
        end
      end
      if (w_val && w_rdy) begin
        if (q_seq.size() == 0) begin
          fail_run("Writeback message seen with no op outstanding");
        end else begin
          check_w_msg(q_uop.pop_front(), q_seq.pop_front(), q_pc.pop_front(),
                      q_waddr.pop_front(), q_wdata.pop_front(), q_wen.pop_front());
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      fail_run("Timeout, the run did not finish within the cycle limit");
    end
  end

  //--------------------------------------------------
  // Directed tests
  //--------------------------------------------------

  task automatic test_jal();
    send_op(cfu_pkg::UOP_JAL, 32'h0000_1000, '0, '0, 32'h0000_0040, 5'd1);
    // Backward jump
    send_op(cfu_pkg::UOP_JAL, 32'h0000_2004, '0, '0, 32'hffff_fff0, 5'd31);
    send_op(cfu_pkg::UOP_JAL, 32'h8000_0000, 32'h5, 32'h7, 32'h000f_fffe, 5'd0);
    // Link and target wrap around
    send_op(cfu_pkg::UOP_JAL, 32'hffff_fffc, '0, '0, 32'h0000_0008, 5'd17);
    drain();
  endtask

  task automatic test_jalr();
    logic [cfu_pkg::XLEN-1:0] op1;
    logic [cfu_pkg::XLEN-1:0] imm;
    logic [cfu_pkg::XLEN-1:0] sum;
    repeat (8) begin
      op1 = rand_word();
      imm = rand_word();
      sum = op1 + imm;
      // Force an odd sum so bit 0 clearing is visible
      if (!sum[0]) begin
        imm = imm ^ 32'd1;
      end
      send_op(cfu_pkg::UOP_JALR, rand_word() & ~32'd3, op1, rand_word(), imm, sum[9:5]);
    end
    drain();
  endtask

  task automatic test_bne();
    logic [cfu_pkg::XLEN-1:0] a;
    repeat (4) begin
      a = rand_word();
      // Equal operands leave the branch not taken
      send_op(cfu_pkg::UOP_BNE, 32'h0000_4000, a, a, 32'h0000_0100, 5'd9);
      // Unequal operands take the branch
      send_op(cfu_pkg::UOP_BNE, 32'h0000_4010, a, a ^ 32'h0001_0000, 32'hffff_ff00, 5'd12);
    end
    drain();
  endtask

  task automatic test_backpressure();
    bp_done = 1'b0;
    fork
      begin
        logic [31:0]              r;
        logic [cfu_pkg::XLEN-1:0] op1;
        cfu_pkg::cfu_uop_e        uop;
        repeat (40) begin
          r = rand_word();
          case (r[1:0])
            2'd0:    uop = cfu_pkg::UOP_JAL;
            2'd1:    uop = cfu_pkg::UOP_JALR;
            default: uop = cfu_pkg::UOP_BNE;
          endcase
          op1 = rand_word();
          send_op(uop, rand_word() & ~32'd3, op1, r[2] ? op1 : rand_word(),
                  rand_word(), r[7:3]);
        end
        bp_done = 1'b1;
      end
      begin
        logic [31:0] r;
        while (!bp_done) begin
          @(negedge clk);
          r     = rand_word();
          w_rdy = r[0];
        end
      end
    join
    w_rdy = 1'b1;
    drain();
  endtask

  task automatic test_stats();
    wb_write(cfu_pkg::STAT_CTRL, 32'd1);
    n_retired = 0;
    n_link    = 0;
    n_squash  = 0;
    send_op(cfu_pkg::UOP_JAL, 32'h0000_0100, '0, '0, 32'h0000_0020, 5'd3);
    send_op(cfu_pkg::UOP_JALR, 32'h0000_0104, 32'h0000_2001, '0, 32'h0000_0010, 5'd4);
    send_op(cfu_pkg::UOP_BNE, 32'h0000_0108, 32'd7, 32'd7, 32'h0000_0040, 5'd0);
    send_op(cfu_pkg::UOP_BNE, 32'h0000_010c, 32'd7, 32'd8, 32'h0000_0040, 5'd0);
    send_op(cfu_pkg::UOP_JAL, 32'h0000_0110, '0, '0, 32'hffff_fff0, 5'd5);
    drain();
    check_stat(cfu_pkg::STAT_RETIRED, n_retired);
    check_stat(cfu_pkg::STAT_LINK, n_link);
    check_stat(cfu_pkg::STAT_SQUASH, n_squash);
    check_stat(cfu_pkg::STAT_CTRL, 32'd0);
    wb_write(cfu_pkg::STAT_CTRL, 32'd1);
    check_stat(cfu_pkg::STAT_RETIRED, 32'd0);
    check_stat(cfu_pkg::STAT_LINK, 32'd0);
    check_stat(cfu_pkg::STAT_SQUASH, 32'd0);
  endtask

  initial begin
    arst_n    = 1'b0;
    d_val     = 1'b0;
    d_pc      = '0;
    d_seq_num = '0;
    d_op1     = '0;
    d_op2     = '0;
    d_imm     = '0;
    d_waddr   = '0;
    d_uop     = cfu_pkg::UOP_JAL;
    w_rdy     = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_wdata  = '0;
    next_seq  = '0;
    n_retired = 0;
    n_link    = 0;
    n_squash  = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    if (!d_rdy || w_val || squash_val || wb_ack) begin
      fail_run("Outputs are not in their idle state after reset");
    end
    test_jal();
    test_jalr();
    test_bne();
    test_backpressure();
    test_stats();
    // Catches an assertion that failed on the last edge of the run
    if (dut.u_sva.fail_count != 0) begin
      fail_run("An assertion in the bound checker failed");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

//--- sources.f
verilog/cfu_pkg.sv
verilog/cfu_issue_buffer.sv
verilog/control_flow_unit.sv
verilog/cfu_stat_regs.sv
verilog/cfu_top.sv
testbench/cfu_sva.sv
testbench/cfu_tb.sv
